/* rtl/scaler_pkg.sv */
package scaler_pkg;

    localparam int PIX_W      = 8;    // gray and color channel
    localparam int COORD_W    = 8;    // coordinates and sizes
    localparam int FRAC_W     = 20;   // source position fraction
    localparam int IMG_ADDR_W = 14;
    localparam int RES_ADDR_W = 16;
    localparam int ROW_SHIFT  = 7;    // 128 words per image row

    // rows and columns where a missing neighbour is repeated
    localparam logic [COORD_W-1:0] EDGE_LO = 8'd0;
    localparam logic [COORD_W-1:0] EDGE_HI = 8'd126;

    localparam int TAP_W = 10;        // sign, 8 integer bits, one half bit
    localparam int ACC_W = 34;        // 21 fraction bits

    // luma weights in 32nds
    localparam logic [4:0] GRAY_WR = 5'd9;
    localparam logic [4:0] GRAY_WG = 5'd19;
    localparam logic [4:0] GRAY_WB = 5'd3;

endpackage

/* rtl/rgb_to_gray.sv */
`timescale 1ns/1ps

module rgb_to_gray (
    input  logic [31:0]                  img_q,
    output logic [scaler_pkg::PIX_W-1:0] gray
);
    import scaler_pkg::*;

    logic [PIX_W+5:0] wsum;       // weighted sum in 1/32 steps
    logic             round_up;

    assign wsum = img_q[23:16] * GRAY_WR
                + img_q[15:8]  * GRAY_WG
                + img_q[7:0]   * GRAY_WB;

    // above one half, or exactly one half with an odd quotient
    assign round_up = wsum[4] && ((wsum[3:0] != 4'd0) || wsum[5]);
    assign gray     = wsum[PIX_W+4:5] + PIX_W'(round_up);   // max 247, no overflow

endmodule

/* rtl/coord_mapper.sv */
`timescale 1ns/1ps

module coord_mapper (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           step,
    input  logic [scaler_pkg::COORD_W-1:0] x0,
    input  logic [scaler_pkg::COORD_W-1:0] y0,
    input  logic [scaler_pkg::COORD_W-1:0] original_w,
    input  logic [scaler_pkg::COORD_W-1:0] original_h,
    input  logic [scaler_pkg::COORD_W-1:0] scaled_w,
    input  logic [scaler_pkg::COORD_W-1:0] scaled_h,
    output logic [scaler_pkg::COORD_W-1:0] src_x,
    output logic [scaler_pkg::COORD_W-1:0] src_y,
    output logic [scaler_pkg::FRAC_W-1:0]  h_frac,
    output logic [scaler_pkg::FRAC_W-1:0]  v_frac,
    output logic                           last
);
    import scaler_pkg::*;

    localparam int MAP_W = 2 * COORD_W + FRAC_W;   // headroom for the product

    logic [COORD_W-1:0] col;
    logic [COORD_W-1:0] row;
    logic [MAP_W-1:0]   h_pos;
    logic [MAP_W-1:0]   v_pos;

    // pos * (orig - 1) / (scaled - 1), fraction in the low FRAC_W bits
    function automatic logic [MAP_W-1:0] axis_map(input logic [COORD_W-1:0] pos,
                                                  input logic [COORD_W-1:0] orig,
                                                  input logic [COORD_W-1:0] scaled);
        logic [MAP_W-1:0] num;
        logic [MAP_W-1:0] den;
        num = {pos, {FRAC_W{1'b0}}} * (orig - 1'b1);
        den = scaled - 1'b1;
        return num / den;
    endfunction

    assign h_pos  = axis_map(col, original_w, scaled_w);
    assign v_pos  = axis_map(row, original_h, scaled_h);
    assign src_x  = h_pos[FRAC_W +: COORD_W] + x0;   // window origin added
    assign src_y  = v_pos[FRAC_W +: COORD_W] + y0;
    assign h_frac = h_pos[FRAC_W-1:0];
    assign v_frac = v_pos[FRAC_W-1:0];
    assign last   = (row == scaled_h);                // past the final raster row

    always_ff @(posedge clk) begin
        if (rst) begin
            col <= '0;
            row <= '0;
        end else if (step) begin
            if (col == scaled_w - 1'b1) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

/* rtl/tap_fetcher.sv */
`timescale 1ns/1ps

module tap_fetcher #(
    parameter int IMG_PITCH_SHIFT = scaler_pkg::ROW_SHIFT
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     fetch_start,
    input  logic                                     fetch_axis,   // 1 walks down a column
    input  logic        [scaler_pkg::COORD_W-1:0]    src_x,
    input  logic        [scaler_pkg::COORD_W-1:0]    src_y,
    input  logic        [31:0]                       img_q,
    output logic                                     img_cen,
    output logic        [scaler_pkg::IMG_ADDR_W-1:0] img_a,
    output logic                                     taps_valid,
    output logic signed [scaler_pkg::TAP_W-1:0]      tap_m1,
    output logic signed [scaler_pkg::TAP_W-1:0]      tap_0,
    output logic signed [scaler_pkg::TAP_W-1:0]      tap_1,
    output logic signed [scaler_pkg::TAP_W-1:0]      tap_2
);
    import scaler_pkg::*;

    localparam int FULL_W = IMG_ADDR_W + 2;   // wide enough to expose an overrun

    logic [FULL_W-1:0]       base;
    logic [FULL_W-1:0]       stride_in;
    logic [FULL_W-1:0]       stride;
    logic [FULL_W-1:0]       rd_addr;
    logic [COORD_W-1:0]      pos;
    logic                    pad_hi;
    logic                    busy;
    logic [2:0]              cnt;
    logic [PIX_W-1:0]        gray;
    logic signed [TAP_W-1:0] gray_tap;

    rgb_to_gray u_rgb_to_gray (
        .img_q (img_q),
        .gray  (gray)
    );

    assign base      = (FULL_W'(src_y) << IMG_PITCH_SHIFT) + FULL_W'(src_x);
    assign stride_in = fetch_axis ? (FULL_W'(1) << IMG_PITCH_SHIFT) : FULL_W'(1);
    assign pos       = fetch_axis ? src_y : src_x;
    assign gray_tap  = {1'b0, gray, 1'b0};          // half-unit form
    assign img_a     = rd_addr[IMG_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            cnt        <= 3'd0;
            img_cen    <= 1'b1;
            taps_valid <= 1'b0;
        end else begin
            taps_valid <= 1'b0;
            if (fetch_start) begin
                busy    <= 1'b1;
                cnt     <= 3'd0;
                img_cen <= 1'b0;
            end else if (busy) begin
                cnt <= cnt + 3'd1;
                if (cnt == 3'd3) begin
                    img_cen <= 1'b1;                // fourth read issued
                end
                if (cnt == 3'd4) begin
                    busy       <= 1'b0;
                    taps_valid <= 1'b1;
                end
            end
        end
    end

    // reads at pos-1, pos, pos+1, pos+2, clamped at the edges
    always_ff @(posedge clk) begin
        if (fetch_start) begin
            stride  <= stride_in;
            pad_hi  <= (pos == EDGE_HI);
            rd_addr <= (pos == EDGE_LO) ? base : base - stride_in;   // tap_m1 repeats tap_0
        end else if (busy) begin
            case (cnt)
                3'd0: rd_addr <= base;
                3'd1: begin
                    rd_addr <= rd_addr + stride;
                    tap_m1  <= gray_tap;
                end
                3'd2: begin
                    if (!pad_hi) begin
                        rd_addr <= rd_addr + stride;    // else tap_2 repeats tap_1
                    end
                    tap_0 <= gray_tap;
                end
                3'd3: tap_1 <= gray_tap;
                3'd4: tap_2 <= gray_tap;
                default: ;
            endcase
        end
    end

    a_addr_range : assert property (@(posedge clk) disable iff (rst)
        !img_cen |-> (rd_addr[FULL_W-1:IMG_ADDR_W] == '0))
        else $error("image read address beyond the image RAM");

endmodule

/* rtl/cubic_eval.sv */
`timescale 1ns/1ps

module cubic_eval (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                eval_start,
    input  logic        [scaler_pkg::FRAC_W-1:0] frac,
    input  logic signed [scaler_pkg::TAP_W-1:0]  tap_m1,
    input  logic signed [scaler_pkg::TAP_W-1:0]  tap_0,
    input  logic signed [scaler_pkg::TAP_W-1:0]  tap_1,
    input  logic signed [scaler_pkg::TAP_W-1:0]  tap_2,
    output logic        [scaler_pkg::PIX_W-1:0]  pixel,
    output logic                                pix_valid
);
    import scaler_pkg::*;

    localparam int COEF_W   = TAP_W + 2;
    localparam int T_W      = FRAC_W + 2;            // sign and one integer bit
    localparam int ACC_FRAC = FRAC_W + 1;
    localparam int INT_W    = ACC_W - 1 - ACC_FRAC;

    logic signed [COEF_W-1:0] coef_a;
    logic signed [COEF_W-1:0] coef_b;
    logic signed [COEF_W-1:0] coef_c;
    logic signed [ACC_W-1:0]  d_term;
    logic signed [T_W-1:0]    t_s;
    logic signed [T_W-1:0]    t_pow;
    logic signed [2*T_W-1:0]  prod;
    logic signed [ACC_W-1:0]  acc;
    logic [PIX_W-1:0]         clamped;
    logic                     busy;
    logic [2:0]               cnt;

    // Catmull-Rom, coefficients kept in half units like the taps
    assign coef_a = -(tap_m1 >>> 1) + tap_0 + (tap_0 >>> 1) - tap_1 - (tap_1 >>> 1)
                  + (tap_2 >>> 1);
    assign coef_b = tap_m1 - (tap_0 <<< 1) - (tap_0 >>> 1) + (tap_1 <<< 1) - (tap_2 >>> 1);
    assign coef_c = (tap_1 >>> 1) - (tap_m1 >>> 1);
    assign d_term = tap_0 <<< FRAC_W;
    assign t_s    = T_W'(frac);

    always_comb begin
        if (acc[ACC_W-1]) begin
            clamped = '0;                                   // negative
        end else if (acc[ACC_W-2:ACC_FRAC] >= INT_W'(255)) begin
            clamped = '1;
        end else begin
            clamped = acc[ACC_FRAC +: PIX_W] + PIX_W'(acc[ACC_FRAC-1]);   // half up
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            cnt       <= 3'd0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            if (eval_start) begin
                busy <= 1'b1;
                cnt  <= 3'd0;
            end else if (busy) begin
                cnt <= cnt + 3'd1;
                if (cnt == 3'd5) begin
                    busy      <= 1'b0;
                    pix_valid <= 1'b1;
                end
            end
        end
    end

    // d + c*t + b*t^2 + a*t^3, one multiply per term
    always_ff @(posedge clk) begin
        if (busy) begin
            case (cnt)
                3'd0: begin
                    prod <= t_s * t_s;
                    acc  <= d_term;
                end
                3'd1: begin
                    t_pow <= {2'b00, prod[2*FRAC_W-1:FRAC_W]};   // t^2
                    acc   <= acc + coef_c * t_s;
                end
                3'd2: begin
                    prod <= t_pow * t_s;
                    acc  <= acc + coef_b * t_pow;
                end
                3'd3: t_pow <= {2'b00, prod[2*FRAC_W-1:FRAC_W]};   // t^3
                3'd4: acc <= acc + coef_a * t_pow;
                3'd5: pixel <= clamped;
                default: ;
            endcase
        end
    end

    a_valid_pulse : assert property (@(posedge clk) disable iff (rst)
        pix_valid |=> !pix_valid)
        else $error("pix_valid held longer than one cycle");

endmodule

/* rtl/scale_ctrl.sv */
`timescale 1ns/1ps

module scale_ctrl (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  enable,
    input  logic                                  last,
    input  logic        [scaler_pkg::FRAC_W-1:0]   h_frac,
    input  logic        [scaler_pkg::FRAC_W-1:0]   v_frac,
    input  logic                                  taps_valid,
    input  logic signed [scaler_pkg::TAP_W-1:0]    tap_0,
    input  logic                                  pix_valid,
    input  logic        [scaler_pkg::PIX_W-1:0]    pixel,
    output logic                                  step,
    output logic                                  fetch_start,
    output logic                                  fetch_axis,
    output logic        [scaler_pkg::FRAC_W-1:0]   frac,
    output logic                                  eval_start,
    output logic                                  result_cen,
    output logic                                  result_wen,
    output logic        [scaler_pkg::PIX_W-1:0]    result_d,
    output logic        [scaler_pkg::RES_ADDR_W-1:0] result_a,
    output logic                                  done
);
    import scaler_pkg::*;

    localparam logic [2:0] ST_START    = 3'd0;
    localparam logic [2:0] ST_MAP      = 3'd1;
    localparam logic [2:0] ST_FETCH    = 3'd2;
    localparam logic [2:0] ST_EVAL     = 3'd3;
    localparam logic [2:0] ST_WRITE    = 3'd4;
    localparam logic [2:0] ST_FINISHED = 3'd5;

    logic [2:0] state;
    logic       exact;
    logic       copy_hit;
    logic       eval_hit;

    assign exact       = (h_frac == '0) && (v_frac == '0);
    assign fetch_axis  = (h_frac == '0);          // column walk when no horizontal fraction
    assign frac        = fetch_axis ? v_frac : h_frac;
    assign fetch_start = (state == ST_MAP) && !last;
    assign eval_start  = (state == ST_FETCH) && taps_valid && !exact;
    assign step        = (state == ST_WRITE);     // mapper moves on after each write
    assign copy_hit    = (state == ST_FETCH) && taps_valid && exact;
    assign eval_hit    = (state == ST_EVAL) && pix_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_START;
            result_cen <= 1'b1;
            result_wen <= 1'b1;
            result_a   <= '0;
            done       <= 1'b0;
        end else begin
            result_cen <= 1'b1;
            result_wen <= 1'b1;
            case (state)
                ST_START: if (enable) state <= ST_MAP;
                ST_MAP: begin
                    if (last) begin
                        state <= ST_FINISHED;
                        done  <= 1'b1;
                    end else begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (copy_hit) begin
                        result_cen <= 1'b0;       // evaluator skipped
                        result_wen <= 1'b0;
                        state      <= ST_WRITE;
                    end else if (taps_valid) begin
                        state <= ST_EVAL;
                    end
                end
                ST_EVAL: begin
                    if (eval_hit) begin
                        result_cen <= 1'b0;
                        result_wen <= 1'b0;
                        state      <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    result_a <= result_a + 1'b1;  // strobe is low this cycle
                    state    <= ST_MAP;
                end
                ST_FINISHED: state <= ST_FINISHED;
                default: state <= ST_START;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (copy_hit) begin
            result_d <= tap_0[PIX_W:1];
        end else if (eval_hit) begin
            result_d <= pixel;
        end
    end

    a_no_write_after_done : assert property (@(posedge clk) disable iff (rst)
        (state == ST_FINISHED) |-> result_cen)
        else $error("result RAM strobed after the last pixel");

endmodule

/* rtl/bicubic_scaler.sv */
`timescale 1ns/1ps

module bicubic_scaler #(
    parameter int IMG_PITCH_SHIFT = scaler_pkg::ROW_SHIFT
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic [scaler_pkg::COORD_W-1:0]    x0,
    input  logic [scaler_pkg::COORD_W-1:0]    y0,
    input  logic [scaler_pkg::COORD_W-1:0]    original_w,
    input  logic [scaler_pkg::COORD_W-1:0]    original_h,
    input  logic [scaler_pkg::COORD_W-1:0]    scaled_w,
    input  logic [scaler_pkg::COORD_W-1:0]    scaled_h,
    input  logic [31:0]                       img_q,
    output logic                              img_cen,
    output logic [scaler_pkg::IMG_ADDR_W-1:0] img_a,
    output logic                              result_cen,
    output logic                              result_wen,
    output logic [scaler_pkg::PIX_W-1:0]      result_d,
    output logic [scaler_pkg::RES_ADDR_W-1:0] result_a,
    output logic                              done
);
    import scaler_pkg::*;

    logic                    step;
    logic                    fetch_start;
    logic                    fetch_axis;
    logic                    eval_start;
    logic                    last;
    logic                    taps_valid;
    logic                    pix_valid;
    logic [COORD_W-1:0]      src_x;
    logic [COORD_W-1:0]      src_y;
    logic [FRAC_W-1:0]       h_frac;
    logic [FRAC_W-1:0]       v_frac;
    logic [FRAC_W-1:0]       frac;
    logic signed [TAP_W-1:0] tap_m1;
    logic signed [TAP_W-1:0] tap_0;
    logic signed [TAP_W-1:0] tap_1;
    logic signed [TAP_W-1:0] tap_2;
    logic [PIX_W-1:0]        pixel;

    scale_ctrl u_scale_ctrl (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .last        (last),
        .h_frac      (h_frac),
        .v_frac      (v_frac),
        .taps_valid  (taps_valid),
        .tap_0       (tap_0),
        .pix_valid   (pix_valid),
        .pixel       (pixel),
        .step        (step),
        .fetch_start (fetch_start),
        .fetch_axis  (fetch_axis),
        .frac        (frac),
        .eval_start  (eval_start),
        .result_cen  (result_cen),
        .result_wen  (result_wen),
        .result_d    (result_d),
        .result_a    (result_a),
        .done        (done)
    );

    coord_mapper u_coord_mapper (
        .clk        (clk),
        .rst        (rst),
        .step       (step),
        .x0         (x0),
        .y0         (y0),
        .original_w (original_w),
        .original_h (original_h),
        .scaled_w   (scaled_w),
        .scaled_h   (scaled_h),
        .src_x      (src_x),
        .src_y      (src_y),
        .h_frac     (h_frac),
        .v_frac     (v_frac),
        .last       (last)
    );

    tap_fetcher #(
        .IMG_PITCH_SHIFT (IMG_PITCH_SHIFT)
    ) u_tap_fetcher (
        .clk         (clk),
        .rst         (rst),
        .fetch_start (fetch_start),
        .fetch_axis  (fetch_axis),
        .src_x       (src_x),
        .src_y       (src_y),
        .img_q       (img_q),
        .img_cen     (img_cen),
        .img_a       (img_a),
        .taps_valid  (taps_valid),
        .tap_m1      (tap_m1),
        .tap_0       (tap_0),
        .tap_1       (tap_1),
        .tap_2       (tap_2)
    );

    cubic_eval u_cubic_eval (
        .clk        (clk),
        .rst        (rst),
        .eval_start (eval_start),
        .frac       (frac),
        .tap_m1     (tap_m1),
        .tap_0      (tap_0),
        .tap_1      (tap_1),
        .tap_2      (tap_2),
        .pixel      (pixel),
        .pix_valid  (pix_valid)
    );

endmodule

/* verification/tb_bicubic_scaler.sv */
`timescale 1ns/1ps

module tb_bicubic_scaler;

    localparam int PITCH      = 128;   // image row pitch in words
    localparam int MEM_WORDS  = 16384;
    localparam int STIM_WORDS = 512;
    localparam int HDR_WORDS  = 9;     // mode x0 y0 ow oh sw sh fill npairs

    logic        clk;
    logic        rst;
    logic        enable;
    logic [7:0]  x0;
    logic [7:0]  y0;
    logic [7:0]  original_w;
    logic [7:0]  original_h;
    logic [7:0]  scaled_w;
    logic [7:0]  scaled_h;
    logic [31:0] img_q;
    logic        img_cen;
    logic [13:0] img_a;
    logic        result_cen;
    logic        result_wen;
    logic [7:0]  result_d;
    logic [15:0] result_a;
    logic        done;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] stim [0:STIM_WORDS-1];

    int errors;
    int test_errors;   // failed checks of the running test
    int tests_run;
    int tests_failed;

    bicubic_scaler u_bicubic_scaler (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .x0         (x0),
        .y0         (y0),
        .original_w (original_w),
        .original_h (original_h),
        .scaled_w   (scaled_w),
        .scaled_h   (scaled_h),
        .img_q      (img_q),
        .img_cen    (img_cen),
        .img_a      (img_a),
        .result_cen (result_cen),
        .result_wen (result_wen),
        .result_d   (result_d),
        .result_a   (result_a),
        .done       (done)
    );

    always #2 clk = ~clk;

    // image RAM, data one cycle after the strobe
    always @(posedge clk) begin
        if (!img_cen) begin
            img_q <= mem[img_a];
        end
    end

    // weights 9, 19, 3 in 32nds, exact halves go to the even neighbour
    function automatic logic [7:0] gray_of(input logic [31:0] word);
        int sum;
        int q;
        int r;
        sum = 9 * word[23:16] + 19 * word[15:8] + 3 * word[7:0];
        q = sum / 32;
        r = sum % 32;
        if (r > 16 || (r == 16 && q % 2 == 1)) begin
            q = q + 1;
        end
        return q[7:0];
    endfunction

    function automatic logic [31:0] fill_word(input int addr);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        r = 8'(addr * 13);
        g = 8'((addr >> 7) * 29 + addr);
        b = 8'(addr ^ (addr >> 5));
        return {8'h00, r, g, b};
    endfunction

    function automatic logic [7:0] expected_byte(input int hdr, input int k);
        int sw;
        int addr;
        sw = stim[hdr + 5];
        if (stim[hdr] == 1) begin
            addr = (stim[hdr + 2] + k / sw) * PITCH + stim[hdr + 1] + k % sw;
            return gray_of(mem[addr]);
        end else if (stim[hdr] == 2) begin
            return gray_of(stim[hdr + 7]);   // constant image
        end
        return stim[hdr + HDR_WORDS + 2 * stim[hdr + 8] + k][7:0];
    endfunction

    // source window widened by one tap before and two taps after
    function automatic bit addr_in_window(input int hdr, input logic [13:0] a);
        int col;
        int row;
        int xs;
        int ys;
        col = int'(a) % PITCH;
        row = int'(a) / PITCH;
        xs  = int'(stim[hdr + 1]);
        ys  = int'(stim[hdr + 2]);
        return (col >= xs - 1) && (col <= xs + int'(stim[hdr + 3]) + 1)
            && (row >= ys - 1) && (row <= ys + int'(stim[hdr + 4]) + 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            test_errors++;
            $display("Error: %s is %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        test_errors++;
        $display("%s at %0t", what, $time);
    endtask

    task automatic check_idle();
        check_value("img_cen", img_cen, 1);
        check_value("result_cen", result_cen, 1);
        check_value("result_wen", result_wen, 1);
        check_value("done", done, 0);
    endtask

    task automatic load_image(input int hdr);
        int n;
        int base;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = (stim[hdr] == 2) ? stim[hdr + 7] : fill_word(a);
        end
        n = stim[hdr + 8];
        base = hdr + HDR_WORDS;
        for (int k = 0; k < n; k++) begin
            mem[stim[base + 2 * k][13:0]] = stim[base + 2 * k + 1];   // override pixel
        end
    endtask

    task automatic run_test(input int hdr, output int next);
        int npix;
        int nwr;
        int gap;
        int limit;
        int cycles;
        int last_wr;
        bit finished;
        npix = stim[hdr + 5] * stim[hdr + 6];
        test_errors = 0;
        tests_run++;
        @(posedge clk);
        rst        <= 1'b1;
        enable     <= 1'b0;
        x0         <= stim[hdr + 1][7:0];
        y0         <= stim[hdr + 2][7:0];
        original_w <= stim[hdr + 3][7:0];
        original_h <= stim[hdr + 4][7:0];
        scaled_w   <= stim[hdr + 5][7:0];
        scaled_h   <= stim[hdr + 6][7:0];
        load_image(hdr);
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_idle();
            end
            @(posedge clk);
        end
        rst <= 1'b0;
        gap = 1 + $urandom % 8;   // idle cycles before enable
        repeat (gap) begin
            @(negedge clk);
            check_idle();
            @(posedge clk);
        end
        enable <= 1'b1;
        nwr = 0;
        cycles = 0;
        last_wr = 0;
        finished = 1'b0;
        limit = 30 * npix + 100;
        while (!finished && cycles < limit) begin
            @(negedge clk);
            cycles++;
            if (!img_cen && !addr_in_window(hdr, img_a)) begin
                note_failure($sformatf("image read at address %h outside the source window",
                                       img_a));
            end
            if (!result_cen) begin
                check_value("result_wen", result_wen, 0);
                check_value("result_a", result_a, nwr);
                if (nwr < npix) begin
                    check_value("result_d", result_d, expected_byte(hdr, nwr));
                end else begin
                    note_failure("more result writes than output pixels");
                end
                nwr++;
                last_wr = cycles;
            end
            finished = done;
        end
        if (!finished) begin
            note_failure("timeout while waiting for done");
        end else begin
            if (cycles - last_wr > 2) begin
                note_failure("done rose more than 2 cycles after the last write");
            end
            repeat (50) begin
                @(negedge clk);
                check_value("result_cen", result_cen, 1);   // no write after done
                check_value("done", done, 1);
            end
        end
        check_value("write count", nwr, npix);
        next = hdr + HDR_WORDS + 2 * stim[hdr + 8] + ((stim[hdr] == 0) ? npix : 0);
        if (test_errors == 0) begin
            $display("test %0d mode %0d passed, %0d pixels", tests_run, stim[hdr], npix);
        end else begin
            tests_failed++;
            $display("test %0d mode %0d FAILED, %0d errors", tests_run, stim[hdr], test_errors);
        end
    endtask

    initial begin
        int idx;
        int next;
        clk        = 1'b0;
        rst        = 1'b1;
        enable     = 1'b0;
        x0         = '0;
        y0         = '0;
        original_w = '0;
        original_h = '0;
        scaled_w   = '0;
        scaled_h   = '0;
        img_q      = '0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h8b56d73d));
        $readmemh("verification/scaler_stim.txt", stim);
        idx = 0;
        while (idx < STIM_WORDS && !$isunknown(stim[idx]) && stim[idx] != 32'hff) begin
            run_test(idx, next);
            idx = next;
        end
        if (tests_run == 0) begin
            note_failure("no test found in the stimulus file");
        end
        $display("tests %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* verification/scaler_stim.txt */
// header: mode x0 y0 orig_w orig_h scaled_w scaled_h fill npairs, then npairs of addr data
// then scaled_w*scaled_h expected bytes for mode 0; mode 1 copy, mode 2 constant, ff ends
// 1:1 window, pattern image
1 05 03 03 02 03 02 0 0
// constant colour upscale 2x2 to 3x3
2 14 14 02 02 03 03 00C86432 0
// horizontal only, row 10 and 11, cols 39..42
0 28 0A 02 02 03 02 0 8
527 202020 528 404040 529 808080 52A 606060
5A7 000000 5A8 FFFFFF 5A9 FFFFFF 5AA 000000
3E 61 7C F7 FF F7
// vertical only, cols 60 and 61, rows 29..32
0 3C 1E 02 02 02 03 0 8
EBC 606060 F3C 202020 FBC A0A0A0 103C 404040
EBD FFFFFF F3D 000000 FBD 000000 103D FFFFFF
1F 00 5F 00 9B 00
// low edge, columns 0..2
0 00 32 02 02 03 02 0 6
1900 A0A0A0 1901 202020 1902 FFFFFF
1980 000000 1981 808080 1982 404040
9B 50 1F 00 42 7C
// high edge, columns 125..127
0 7E 3C 02 02 03 02 0 6
1E7D 404040 1E7E FFFFFF 1E7F 202020
1EFD 808080 1EFE 606060 1EFF A0A0A0
F7 97 1F 5D 7A 9B
// low edge on the vertical axis, rows 0..2
0 50 00 02 02 02 03 0 6
050 606060 0D0 202020 150 808080
051 FFFFFF 0D1 FFFFFF 151 000000
5D F7 38 FF 1F F7
FF

/* list.f */
rtl/scaler_pkg.sv
rtl/rgb_to_gray.sv
rtl/coord_mapper.sv
rtl/tap_fetcher.sv
rtl/cubic_eval.sv
rtl/scale_ctrl.sv
rtl/bicubic_scaler.sv
verification/tb_bicubic_scaler.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bicubic_scaler
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(wildcard rtl/*.sv) $(wildcard verification/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
